// File: Bender.yml
package:
  name: system_bus

sources:
  - system_pkg.sv
  - bus_controller.sv
  - address_decoder.sv
  - ms_timer.sv
  - input_ports.sv
  - work_ram.sv
  - system_top.sv
  - target: test
    files:
      - tb_system.sv

// File: address_decoder.sv
`timescale 1ns/1ps

module address_decoder
	import system_pkg::*;
#(
	parameter int wkram_addr_width = 14
)
(
	input  bus_access_t access,
	output io_region_e  region,
	output bus_data_t   offset
);

	logic [7:0]  page;
	logic [13:0] wkram_index;
	logic        wkram_hit;

	assign page        = access.addr[15:8];
	assign wkram_index = access.addr[13:0];

	// RAM fills the window from 0xC000 upwards
	assign wkram_hit = (access.addr[15:14] == wkram_top)
		&& ((wkram_index >> wkram_addr_width) == 14'd0);

	always_comb
	begin
		if (wkram_hit)
			region = region_wkram;
		else if (page == joystick_page)
			region = region_joystick;
		else if (page == ps2_key_page)
			region = region_ps2_key;
		else if (page == timer_page)
			region = region_timer;
		else if (access.addr[15:4] == pause_page)
			region = region_pause;
		else
			region = region_none;
	end

	// Byte index within the input word
	always_comb
	begin
		unique case (region)
			region_joystick:
				offset = {6'd0, access.addr[1:0]};
			region_ps2_key, region_timer:
				offset = {7'd0, access.addr[0]};
			default:
				offset = '0;
		endcase
	end

endmodule

// File: bus_controller.sv
`timescale 1ns/1ps

module bus_controller
	import system_pkg::*;
(
	input  logic          clk_24,
	input  logic          reset,
	input  axi_lite_req_t axi_req,
	output axi_lite_rsp_t axi_rsp,
	output bus_access_t   access,
	input  io_region_e    region,
	input  bus_data_t     ram_rdata,
	input  bus_data_t     port_rdata
);

	bus_state_e state;
	io_region_e region_q;
	bus_data_t  rdata_q;
	bus_data_t  read_sel;
	logic       write_accept;
	logic       read_accept;
	logic       write_pending;

	// A write in progress on either channel blocks the read channel
	assign write_pending = axi_req.awvalid || axi_req.wvalid;
	assign write_accept  = (state == st_idle) && axi_req.awvalid && axi_req.wvalid;
	assign read_accept   = (state == st_idle) && axi_req.arvalid && !write_pending;

	always_comb
	begin
		axi_rsp.awready = write_accept;
		axi_rsp.wready  = write_accept;
		axi_rsp.bvalid  = (state == st_write_resp);
		axi_rsp.bresp   = resp_okay;
		axi_rsp.arready = read_accept;
		axi_rsp.rvalid  = (state == st_read_resp);
		axi_rsp.rdata   = rdata_q;
		axi_rsp.rresp   = resp_okay;
	end

	// Internal access lives only in the accept cycle
	always_comb
	begin
		access.addr  = write_accept ? axi_req.awaddr : axi_req.araddr;
		access.wdata = axi_req.wdata;
		access.wr    = write_accept;
		access.rd    = read_accept;
	end

	// Read source by the region seen at accept
	always_comb
	begin
		unique case (region_q)
			region_wkram:
				read_sel = ram_rdata;
			region_joystick, region_ps2_key, region_timer:
				read_sel = port_rdata;
			default:
				read_sel = '0;
		endcase
	end

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			state <= st_idle;
		end
		else
		begin
			unique case (state)
				st_idle:
				begin
					if (write_accept)
						state <= st_write_resp;
					else if (read_accept)
						state <= st_read;
				end
				// RAM and port data settle during this cycle
				st_read:
					state <= st_read_resp;
				st_read_resp:
				begin
					if (axi_req.rready)
						state <= st_idle;
				end
				st_write_resp:
				begin
					if (axi_req.bready)
						state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (read_accept)
			region_q <= region;
		if (state == st_read)
			rdata_q <= read_sel;
	end

	assert property (@(posedge clk_24) disable iff (reset)
		!(axi_rsp.bvalid && axi_rsp.rvalid));

	assert property (@(posedge clk_24) disable iff (reset)
		!(access.wr && access.rd));

endmodule

// File: compile.f
system_pkg.sv
bus_controller.sv
address_decoder.sv
ms_timer.sv
input_ports.sv
work_ram.sv
system_top.sv
tb_system.sv

// File: input_ports.sv
`timescale 1ns/1ps

module input_ports
	import system_pkg::*;
(
	input  logic        clk_24,
	input  logic        reset,
	input  bus_access_t access,
	input  io_region_e  region,
	input  bus_data_t   offset,
	input  logic [31:0] joystick,
	input  logic [10:0] ps2_key,
	input  logic        pause,
	input  ms_count_t   ms_count,
	output logic        timer_restart,
	output logic        pause_request,
	output bus_data_t   rdata
);

	io_region_e  region_q;
	bus_data_t   offset_q;
	logic [15:0] ps2_word;

	assign ps2_word      = {5'd0, ps2_key};
	assign timer_restart = access.wr && (region == region_timer);

	// Hold the read target so data lines up with the RAM latency
	always_ff @(posedge clk_24)
	begin
		if (reset)
			region_q <= region_none;
		else if (access.rd)
			region_q <= region;
		if (access.rd)
			offset_q <= offset;
	end

	always_comb
	begin
		unique case (region_q)
			region_joystick:
				rdata = joystick[{offset_q[1:0], 3'd0} +: 8];
			region_ps2_key:
				rdata = ps2_word[{offset_q[0], 3'd0} +: 8];
			region_timer:
				rdata = ms_count[{offset_q[0], 3'd0} +: 8];
			default:
				rdata = '0;
		endcase
	end

	// External pause has priority over a set request
	always_ff @(posedge clk_24)
	begin
		if (reset || pause)
			pause_request <= 1'b0;
		else if (access.wr && (region == region_pause))
			pause_request <= 1'b1;
	end

endmodule

// File: ms_timer.sv
`timescale 1ns/1ps

module ms_timer
	import system_pkg::*;
#(
	parameter int cycles_per_ms = 24000
)
(
	input  logic      clk_24,
	input  logic      reset,
	input  logic      restart,
	output ms_count_t count
);

	localparam int presc_width = $clog2(cycles_per_ms + 1);
	localparam logic [presc_width-1:0] presc_last = presc_width'(cycles_per_ms - 1);

	logic [presc_width-1:0] prescaler;

	always_ff @(posedge clk_24)
	begin
		if (reset || restart)
		begin
			prescaler <= '0;
			count     <= '0;
		end
		else if (prescaler == presc_last)
		begin
			prescaler <= '0;
			// Wraps at 16 bits
			count     <= count + 1'b1;
		end
		else
		begin
			prescaler <= prescaler + 1'b1;
		end
	end

	assert property (@(posedge clk_24) disable iff (reset)
		prescaler < presc_width'(cycles_per_ms));

endmodule

// File: system_pkg.sv
package system_pkg;

	// Widths that carry a meaning on the system bus
	typedef logic [15:0] bus_addr_t;
	typedef logic [7:0]  bus_data_t;
	typedef logic [15:0] ms_count_t;

	// AXI4-Lite signals driven by the external master
	typedef struct packed {
		logic      awvalid;
		bus_addr_t awaddr;
		logic      wvalid;
		bus_data_t wdata;
		logic      bready;
		logic      arvalid;
		bus_addr_t araddr;
		logic      rready;
	} axi_lite_req_t;

	// AXI4-Lite signals driven by the system
	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		bus_data_t  rdata;
		logic [1:0] rresp;
	} axi_lite_rsp_t;

	// One single-cycle access on the internal bus
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic      wr;
		logic      rd;
	} bus_access_t;

	typedef enum logic [2:0] {
		region_none,
		region_joystick,
		region_ps2_key,
		region_timer,
		region_pause,
		region_wkram
	} io_region_e;

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_read_resp,
		st_write_resp
	} bus_state_e;

	// Memory map pages
	localparam logic [7:0]  joystick_page = 8'h81;
	localparam logic [7:0]  ps2_key_page  = 8'h86;
	localparam logic [7:0]  timer_page    = 8'h89;
	localparam logic [11:0] pause_page    = 12'h8A3;
	localparam logic [1:0]  wkram_top     = 2'b11;

	localparam logic [1:0] resp_okay = 2'b00;

endpackage

// File: system_top.sv
`timescale 1ns/1ps

module system_top
	import system_pkg::*;
#(
	parameter int wkram_addr_width = 14,
	parameter int cycles_per_ms    = 24000
)
(
	input  logic          clk_24,
	input  logic          reset,
	input  axi_lite_req_t axi_req,
	output axi_lite_rsp_t axi_rsp,
	input  logic [31:0]   joystick,
	input  logic [10:0]   ps2_key,
	input  logic          pause,
	output logic          pause_request
);

	bus_access_t access;
	io_region_e  region;
	bus_data_t   offset;
	bus_data_t   ram_rdata;
	bus_data_t   port_rdata;
	ms_count_t   ms_count;
	logic        timer_restart;
	logic        wkram_selected;

	assign wkram_selected = (region == region_wkram);

	bus_controller u_bus_controller (
		.clk_24     (clk_24),
		.reset      (reset),
		.axi_req    (axi_req),
		.axi_rsp    (axi_rsp),
		.access     (access),
		.region     (region),
		.ram_rdata  (ram_rdata),
		.port_rdata (port_rdata)
	);

	address_decoder #(
		.wkram_addr_width (wkram_addr_width)
	) u_address_decoder (
		.access (access),
		.region (region),
		.offset (offset)
	);

	// Millisecond counter, restarted by a write to its page
	ms_timer #(
		.cycles_per_ms (cycles_per_ms)
	) u_ms_timer (
		.clk_24  (clk_24),
		.reset   (reset),
		.restart (timer_restart),
		.count   (ms_count)
	);

	input_ports u_input_ports (
		.clk_24        (clk_24),
		.reset         (reset),
		.access        (access),
		.region        (region),
		.offset        (offset),
		.joystick      (joystick),
		.ps2_key       (ps2_key),
		.pause         (pause),
		.ms_count      (ms_count),
		.timer_restart (timer_restart),
		.pause_request (pause_request),
		.rdata         (port_rdata)
	);

	// Work RAM at 0xC000
	work_ram #(
		.wkram_addr_width (wkram_addr_width)
	) u_work_ram (
		.clk_24   (clk_24),
		.access   (access),
		.selected (wkram_selected),
		.rdata    (ram_rdata)
	);

endmodule

// File: tb_system.sv
`timescale 1ns/1ps

module tb_system
	import system_pkg::*;
();

	localparam int cycles_per_ms = 24;
	localparam int wait_limit    = 64;

	logic          clk_24;
	logic          reset;
	axi_lite_req_t axi_req;
	axi_lite_rsp_t axi_rsp;
	logic [31:0]   joystick;
	logic [10:0]   ps2_key;
	logic          pause;
	logic          pause_request;

	integer     seed = 65675;
	int         errors;
	int         checks;
	int         test_num;
	int         test_start_errors;
	int         i;
	int         k;
	bus_addr_t  addr_pool [16];
	bus_data_t  data_pool [16];
	bus_data_t  data;
	logic [1:0] resp;
	logic [1:0] wr_resp;
	logic [31:0] joy_value;
	logic [10:0] key_value;

	system_top #(
		.cycles_per_ms (cycles_per_ms)
	) UUT (
		.clk_24        (clk_24),
		.reset         (reset),
		.axi_req       (axi_req),
		.axi_rsp       (axi_rsp),
		.joystick      (joystick),
		.ps2_key       (ps2_key),
		.pause         (pause),
		.pause_request (pause_request)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever #5 clk_24 = ~clk_24;
	end

	function automatic void rule_broken(input string what);
		errors++;
		$display("AXI rule broken: %s", what);
	endfunction

	// Payload holds while valid waits for ready
	assert property (@(posedge clk_24) disable iff (reset)
		axi_req.awvalid && !axi_rsp.awready |=> axi_req.awvalid && $stable(axi_req.awaddr))
		else rule_broken("write address dropped or changed before awready");
	assert property (@(posedge clk_24) disable iff (reset)
		axi_req.wvalid && !axi_rsp.wready |=> axi_req.wvalid && $stable(axi_req.wdata))
		else rule_broken("write data dropped or changed before wready");
	assert property (@(posedge clk_24) disable iff (reset)
		axi_req.arvalid && !axi_rsp.arready |=> axi_req.arvalid && $stable(axi_req.araddr))
		else rule_broken("read address dropped or changed before arready");
	assert property (@(posedge clk_24) disable iff (reset)
		axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid && $stable(axi_rsp.rdata))
		else rule_broken("read data dropped or changed before rready");
	assert property (@(posedge clk_24) disable iff (reset)
		axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid)
		else rule_broken("write response dropped before bready");

	// Responses only follow an accepted request
	assert property (@(posedge clk_24) disable iff (reset)
		$rose(axi_rsp.bvalid) |-> $past(axi_req.awvalid && axi_rsp.awready))
		else rule_broken("write response without an accepted write");
	assert property (@(posedge clk_24) disable iff (reset)
		$rose(axi_rsp.rvalid) |-> $past(axi_req.arvalid && axi_rsp.arready, 2))
		else rule_broken("read data without an accepted read two cycles before");

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			errors++;
			$display("ERROR %s: expected 0x%h, got 0x%h", name, expected, got);
		end
	endtask

	task automatic check_range(input string name, input logic [15:0] got,
		input logic [15:0] lo, input logic [15:0] hi);
		checks++;
		assert (got >= lo && got <= hi)
		else
		begin
			errors++;
			$display("ERROR %s: expected 0x%h to 0x%h, got 0x%h", name, lo, hi, got);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout: no %s within %0d cycles", what, wait_limit);
		$display("tests failed");
		$finish;
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (errors == test_start_errors)
			$display("Test %0d %s: ok", test_num, name);
		else
			$display("Test %0d %s: %0d errors", test_num, name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// bready follows bvalid by one cycle
	task automatic axi_write(input bus_addr_t addr, input bus_data_t wdata,
		output logic [1:0] bresp);
		int cycles;
		@(posedge clk_24);
		axi_req.awvalid <= 1'b1;
		axi_req.awaddr  <= addr;
		axi_req.wvalid  <= 1'b1;
		axi_req.wdata   <= wdata;
		axi_req.bready  <= 1'b0;
		cycles = 0;
		@(negedge clk_24);
		while (!(axi_rsp.awready && axi_rsp.wready))
		begin
			cycles++;
			if (cycles > wait_limit)
				abort_on_timeout("awready and wready");
			@(negedge clk_24);
		end
		@(posedge clk_24);
		axi_req.awvalid <= 1'b0;
		axi_req.wvalid  <= 1'b0;
		cycles = 0;
		@(negedge clk_24);
		while (!axi_rsp.bvalid)
		begin
			cycles++;
			if (cycles > wait_limit)
				abort_on_timeout("bvalid");
			@(negedge clk_24);
		end
		bresp = axi_rsp.bresp;
		@(posedge clk_24);
		axi_req.bready <= 1'b1;
		@(posedge clk_24);
		axi_req.bready <= 1'b0;
	endtask

	// hold is the number of cycles rready stays low once rvalid is up
	task automatic axi_read(input bus_addr_t addr, input int hold,
		output bus_data_t rdata, output logic [1:0] rresp);
		int cycles;
		@(posedge clk_24);
		axi_req.arvalid <= 1'b1;
		axi_req.araddr  <= addr;
		axi_req.rready  <= (hold == 0);
		cycles = 0;
		@(negedge clk_24);
		while (!axi_rsp.arready)
		begin
			cycles++;
			if (cycles > wait_limit)
				abort_on_timeout("arready");
			@(negedge clk_24);
		end
		@(posedge clk_24);
		axi_req.arvalid <= 1'b0;
		cycles = 0;
		@(negedge clk_24);
		while (!axi_rsp.rvalid)
		begin
			cycles++;
			if (cycles > wait_limit)
				abort_on_timeout("rvalid");
			@(negedge clk_24);
		end
		rdata = axi_rsp.rdata;
		rresp = axi_rsp.rresp;
		repeat (hold)
		begin
			@(negedge clk_24);
			check_value("rvalid", axi_rsp.rvalid, 1'b1);
			check_value("rdata", axi_rsp.rdata, rdata);
		end
		if (hold > 0)
		begin
			@(posedge clk_24);
			axi_req.rready <= 1'b1;
		end
		@(posedge clk_24);
		axi_req.rready <= 1'b0;
	endtask

	initial
	begin
		reset    = 1'b1;
		axi_req  = '0;
		joystick = '0;
		ps2_key  = '0;
		pause    = 1'b0;
		errors   = 0;
		checks   = 0;
		test_num = 0;
		test_start_errors = 0;
		repeat (5) @(posedge clk_24);
		reset <= 1'b0;

		@(negedge clk_24);
		check_value("awready", axi_rsp.awready, 1'b0);
		check_value("wready", axi_rsp.wready, 1'b0);
		check_value("arready", axi_rsp.arready, 1'b0);
		check_value("bvalid", axi_rsp.bvalid, 1'b0);
		check_value("rvalid", axi_rsp.rvalid, 1'b0);
		check_value("pause_request", pause_request, 1'b0);
		finish_test("reset state");

		// One address per 1 KB block keeps the pool free of duplicates
		for (i = 0; i < 16; i++)
		begin
			addr_pool[i] = 16'hC000 | bus_addr_t'(i << 10) | (bus_addr_t'($random(seed)) & 16'h03FF);
			data_pool[i] = $random(seed);
			axi_write(addr_pool[i], data_pool[i], wr_resp);
			check_value("bresp", wr_resp, resp_okay);
		end
		for (i = 0; i < 32; i++)
		begin
			k = $unsigned($random(seed)) % 16;
			data_pool[k] = $random(seed);
			axi_write(addr_pool[k], data_pool[k], wr_resp);
			check_value("bresp", wr_resp, resp_okay);
		end
		for (i = 0; i < 16; i++)
		begin
			axi_read(addr_pool[i], 0, data, resp);
			check_value("rdata", data, data_pool[i]);
			check_value("rresp", resp, resp_okay);
		end
		finish_test("work RAM");

		joy_value = $random(seed);
		key_value = $random(seed);
		@(posedge clk_24);
		joystick <= joy_value;
		ps2_key  <= key_value;
		for (i = 0; i < 4; i++)
		begin
			axi_read(bus_addr_t'(16'h8100 + i), 0, data, resp);
			check_value("joystick byte", data, joy_value[8*i +: 8]);
		end
		axi_read(16'h8600, 0, data, resp);
		check_value("ps2_key low byte", data, key_value[7:0]);
		axi_read(16'h8601, 0, data, resp);
		check_value("ps2_key high byte", data, {5'd0, key_value[10:8]});
		finish_test("inputs");

		axi_write(16'h8900, 8'h00, wr_resp);
		axi_read(16'h8900, 0, data, resp);
		check_range("timer low byte", data, 16'd0, 16'd1);
		repeat (10 * cycles_per_ms) @(posedge clk_24);
		axi_read(16'h8900, 0, data, resp);
		check_range("timer low byte", data, 16'd9, 16'd11);
		axi_read(16'h8901, 0, data, resp);
		check_value("timer high byte", data, 8'h00);
		finish_test("timer");

		@(negedge clk_24);
		check_value("pause_request", pause_request, 1'b0);
		axi_write(16'h8A30, 8'h01, wr_resp);
		@(negedge clk_24);
		check_value("pause_request", pause_request, 1'b1);
		@(posedge clk_24);
		pause <= 1'b1;
		@(posedge clk_24);
		pause <= 1'b0;
		@(negedge clk_24);
		check_value("pause_request", pause_request, 1'b0);
		finish_test("pause latch");

		axi_read(16'h0123, 0, data, resp);
		check_value("rdata", data, 8'h00);
		check_value("rresp", resp, resp_okay);
		// A write arrives while the read data is held back
		fork
			axi_read(addr_pool[3], 6, data, resp);
			begin
				repeat (3) @(posedge clk_24);
				axi_write(addr_pool[5], 8'h5A, wr_resp);
			end
		join
		check_value("rdata", data, data_pool[3]);
		check_value("rresp", resp, resp_okay);
		check_value("bresp", wr_resp, resp_okay);
		data_pool[5] = 8'h5A;
		axi_read(addr_pool[5], 0, data, resp);
		check_value("rdata", data, data_pool[5]);
		// Write and read raised together, the write is served first
		data_pool[6] = ~data_pool[6];
		fork
			axi_write(addr_pool[6], data_pool[6], wr_resp);
			axi_read(addr_pool[6], 0, data, resp);
		join
		check_value("rdata", data, data_pool[6]);
		check_value("bresp", wr_resp, resp_okay);
		finish_test("unmapped and back-pressure");

		$display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: work_ram.sv
`timescale 1ns/1ps

module work_ram
	import system_pkg::*;
#(
	parameter int wkram_addr_width = 14
)
(
	input  logic        clk_24,
	input  bus_access_t access,
	input  logic        selected,
	output bus_data_t   rdata
);

	localparam int depth = 2 ** wkram_addr_width;

	bus_data_t                   mem [depth];
	logic [wkram_addr_width-1:0] index;

	assign index = access.addr[wkram_addr_width-1:0];

	// Read every cycle, one clock of latency
	always_ff @(posedge clk_24)
	begin
		if (access.wr && selected)
			mem[index] <= access.wdata;
		rdata <= mem[index];
	end

endmodule
